//--- flist.f
hw/mem_bank_pkg.sv
hw/block_ram.sv
hw/banked_memory.sv
hw/port_map_table.sv
hw/port_crossbar.sv
hw/memory_bank.sv
verif/memory_bank_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the memory bank testbench with Verilator, runs it and judges the log
set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log
sim_bin=memory_bank_sim

verilator --binary --assert --timing \
  --timescale 1ns/100ps \
  --top-module memory_bank_tb \
  -f flist.f \
  -o "$sim_bin"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TESTS FAILED" "$log_file"; then
  echo "Failure reported in $log_file"
  exit 1
fi
echo "No failure reported in $log_file"
exit 0

//--- verif/memory_bank_tb.sv
// Testbench of the memory bank at the package default geometry
// Every memory is first filled with an address pattern, so every read has a known word
// A reference model predicts each read port and assertions compare on the falling edge
`timescale 1ns/100ps

module memory_bank_tb;

  localparam int dw     = mem_bank_pkg::DATA_WIDTH_DEF;
  localparam int n_addr = mem_bank_pkg::NUM_ADDRESSES_DEF;
  localparam int blk    = mem_bank_pkg::BLOCK_DEPTH_DEF;
  localparam int n_mem  = mem_bank_pkg::NUM_MEMORIES_DEF;
  localparam int n_rp   = mem_bank_pkg::NUM_READ_PORTS_DEF;
  localparam int n_wp   = mem_bank_pkg::NUM_WRITE_PORTS_DEF;
  localparam int aw     = $clog2(n_addr);
  localparam int bw     = $clog2(blk);               // Address bits inside a block
  localparam int mw     = $clog2(n_mem);
  localparam int rpw    = $clog2(n_rp);
  localparam int wpw    = $clog2(n_wp);
  localparam int period = 100;
  localparam int planned_cycles = n_addr + 400;      // Fill plus directed traffic

  logic                clk, rst, cmd_assign, cmd_unassign;
  logic [rpw-1:0]      read_port;
  logic [wpw-1:0]      write_port;
  logic [mw-1:0]       memory;
  logic [n_wp-1:0]     write_in;
  logic [n_wp*aw-1:0]  write_addr_in;
  logic [n_wp*dw-1:0]  write_data_in;
  logic [n_rp-1:0]     read_in;
  logic [n_rp*aw-1:0]  read_addr_in;
  logic [n_rp-1:0]     read_valid_out;
  logic [n_rp*dw-1:0]  read_data_out;

  // Reference model state
  logic [dw-1:0]       ref_mem [n_mem][n_addr];
  logic [dw-1:0]       mem_last [n_mem];             // Word each memory read last
  logic [n_mem-1:0]    mem_has_read, mem_rd;
  logic [rpw-1:0]      t_read_sel [n_mem];
  logic [wpw-1:0]      t_write_sel [n_mem];
  logic [n_mem-1:0]    t_read_en, t_write_en;
  logic [mw-1:0]       t_port_mem [n_rp];
  logic [n_rp-1:0]     t_bound;
  logic [n_rp-1:0]     exp_valid, exp_check;         // Data checked unless never read
  logic [dw-1:0]       exp_data [n_rp];
  int                  error_count = 0;
  integer              seed = 32'h1df6_b9af;
  logic [aw-1:0]       addr_list [$];

  memory_bank memory_bank_i (
    .clk            (clk),
    .rst            (rst),
    .cmd_assign     (cmd_assign),
    .cmd_unassign   (cmd_unassign),
    .read_port      (read_port),
    .write_port     (write_port),
    .memory         (memory),
    .write_in       (write_in),
    .write_addr_in  (write_addr_in),
    .write_data_in  (write_data_in),
    .read_in        (read_in),
    .read_addr_in   (read_addr_in),
    .read_valid_out (read_valid_out),
    .read_data_out  (read_data_out)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Reference model on the rising edge
  // --------------------------------------------------------------------------
  always @(posedge clk) begin : model_update
    logic [aw-1:0] a;
    if (!rst) begin
      t_read_en  = '0;
      t_write_en = '0;
      t_bound    = '0;
      mem_rd     = '0;
      mem_has_read = '0;
      exp_valid  = '0;
      exp_check  = '1;                               // Unbound ports read zero
      for (int m = 0; m < n_mem; m++) begin
        t_read_sel[m]  = '0;
        t_write_sel[m] = '0;
      end
      for (int r = 0; r < n_rp; r++) begin
        t_port_mem[r] = '0;
        exp_data[r]   = '0;
      end
    end else begin
      for (int m = 0; m < n_mem; m++) begin
        mem_rd[m] = t_read_en[m] & read_in[t_read_sel[m]];
        if (mem_rd[m]) begin
          a = read_addr_in[t_read_sel[m]*aw +: aw];
          mem_last[m]     = ref_mem[m][a];
          mem_has_read[m] = 1'b1;
        end
      end
      // Writes land after the reads so a collision reads the old word
      for (int m = 0; m < n_mem; m++) begin
        if (t_write_en[m] && write_in[t_write_sel[m]]) begin  // All memories on the port
          a = write_addr_in[t_write_sel[m]*aw +: aw];
          ref_mem[m][a] = write_data_in[t_write_sel[m]*dw +: dw];
        end
      end
      if (cmd_assign) begin                          // Assign wins over unassign
        t_read_sel[memory]    = read_port;
        t_write_sel[memory]   = write_port;
        t_read_en[memory]     = 1'b1;
        t_write_en[memory]    = 1'b1;
        t_port_mem[read_port] = memory;
        t_bound[read_port]    = 1'b1;
      end else if (cmd_unassign) begin
        t_read_en[memory]  = 1'b0;
        t_write_en[memory] = 1'b0;
        t_bound[read_port] = 1'b0;
      end
      for (int r = 0; r < n_rp; r++) begin           // Outputs use the updated table
        exp_valid[r] = t_bound[r] & mem_rd[t_port_mem[r]];
        exp_check[r] = !t_bound[r] || mem_has_read[t_port_mem[r]];
        exp_data[r]  = t_bound[r] ? mem_last[t_port_mem[r]] : '0;
      end
    end
  end

  // Checked on the falling edge where outputs and model have settled
  for (genvar r = 0; r < n_rp; r++) begin : g_check
    assert property (@(negedge clk) disable iff (!rst) read_valid_out[r] == exp_valid[r])
      else begin
        $display("Error at %0t ns: read port %0d valid %0b, expected %0b",
                 $time, r, read_valid_out[r], exp_valid[r]);
        error_count++;
      end
    assert property (@(negedge clk) disable iff (!rst)
                     !exp_check[r] || read_data_out[r*dw +: dw] == exp_data[r])
      else begin
        $display("Error at %0t ns: read port %0d data %h, expected %h",
                 $time, r, read_data_out[r*dw +: dw], exp_data[r]);
        error_count++;
      end
  end

  // --------------------------------------------------------------------------
  // Stimulus helpers that drive 10 ns after the rising edge
  // --------------------------------------------------------------------------
  task automatic tick();
    @(posedge clk);
    #10;
    cmd_assign   = 1'b0;                             // Strobes last one cycle
    cmd_unassign = 1'b0;
    write_in     = '0;
    read_in      = '0;
  endtask

  task automatic assign_mem(input int m, input int r, input int w);
    cmd_assign = 1'b1;
    memory     = mw'(m);
    read_port  = rpw'(r);
    write_port = wpw'(w);
    tick();
  endtask

  task automatic unassign_mem(input int m, input int r);
    cmd_unassign = 1'b1;
    memory       = mw'(m);
    read_port    = rpw'(r);
    tick();
  endtask

  task automatic set_write(input int w, input logic [aw-1:0] a, input logic [dw-1:0] d);
    write_in[w]             = 1'b1;
    write_addr_in[w*aw +: aw] = a;
    write_data_in[w*dw +: dw] = d;
  endtask

  task automatic set_read(input int r, input logic [aw-1:0] a);
    read_in[r]               = 1'b1;
    read_addr_in[r*aw +: aw] = a;
  endtask

  function automatic logic [aw-1:0] rand_addr();
    return aw'($random(seed));
  endfunction

  function automatic logic [dw-1:0] rand_word();
    return dw'($random(seed));
  endfunction

  function automatic logic [dw-1:0] fill_word(input logic [aw-1:0] a);
    return dw'({~a, 8'h5a, a});                      // Every address bit shows twice
  endfunction

  initial begin : watchdog
    #((planned_cycles + 100) * period);
    $display("Timeout: stimulus did not finish within %0d cycles", planned_cycles + 100);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [aw-1:0] a;
    logic [dw-1:0] d;
    rst           = 1'b0;
    cmd_assign    = 1'b0;
    cmd_unassign  = 1'b0;
    read_port     = '0;
    write_port    = '0;
    memory        = '0;
    write_in      = '0;
    write_addr_in = '0;
    write_data_in = '0;
    read_in       = '0;
    read_addr_in  = '0;
    repeat (2) @(posedge clk);
    #10;
    rst = 1'b1;

    for (int i = 0; i < 4; i++) begin                // Nothing bound yet so ports read zero
      set_read(0, rand_addr());
      set_read(1, rand_addr());
      tick();
    end

    // ------------------------------------------------------------------------
    // Fill all memories at once through write port 0, then release them
    // ------------------------------------------------------------------------
    for (int m = 0; m < n_mem; m++) assign_mem(m, m % n_rp, 0);
    for (int i = 0; i < n_addr; i++) begin
      set_write(0, aw'(i), fill_word(aw'(i)));
      tick();
    end
    for (int m = 0; m < n_mem; m++) unassign_mem(m, m % n_rp);

    assign_mem(0, 0, 0);                             // Single memory write and read back
    for (int i = 0; i < 16; i++) begin
      a = rand_addr();
      set_write(0, a, rand_word());
      tick();
      set_read(0, a);
      tick();
    end

    addr_list.delete();                              // Four words in every block
    for (int b = 0; b < n_addr / blk; b++) begin
      for (int i = 0; i < 4; i++) begin
        a = rand_addr();
        a[aw-1:bw] = (aw-bw)'(b);
        addr_list.push_back(a);
        set_write(0, a, rand_word());
        tick();
      end
    end
    foreach (addr_list[i]) begin                     // Back to back reads across blocks
      set_read(0, addr_list[i]);
      tick();
    end
    for (int i = 0; i < 2; i++) begin                // Address moves to other blocks without a read
      a = rand_addr();
      a[aw-1:bw] = (aw-bw)'(i);                      // Last read was in the top block
      read_addr_in[0 +: aw] = a;
      tick();
    end

    // ------------------------------------------------------------------------
    // Two memories on separate ports return their own data at the same addresses
    // ------------------------------------------------------------------------
    assign_mem(1, 0, 1);
    assign_mem(2, 1, 0);
    addr_list.delete();
    for (int i = 0; i < 12; i++) begin
      a = rand_addr();
      addr_list.push_back(a);
      set_write(0, a, rand_word());
      set_write(1, a, rand_word());
      tick();
    end
    foreach (addr_list[i]) begin
      set_read(0, addr_list[i]);
      set_read(1, addr_list[i]);
      tick();
    end

    assign_mem(3, 1, 0);                             // Memories 0, 2 and 3 share port 0
    addr_list.delete();
    for (int i = 0; i < 8; i++) begin
      a = rand_addr();
      addr_list.push_back(a);
      set_write(0, a, rand_word());
      tick();
    end
    foreach (addr_list[i]) begin
      set_read(1, addr_list[i]);
      tick();
    end
    assign_mem(0, 0, 0);                             // Memory 0 saw the same writes
    foreach (addr_list[i]) begin
      set_read(0, addr_list[i]);
      tick();
    end

    unassign_mem(3, 1);                              // Port 1 reads zero and memory 3 drops writes
    foreach (addr_list[i]) begin
      set_read(1, addr_list[i]);
      set_write(0, addr_list[i], rand_word());
      tick();
    end
    assign_mem(3, 1, 1);                             // Old words still in memory 3
    foreach (addr_list[i]) begin
      set_read(1, addr_list[i]);
      tick();
    end

    for (int i = 0; i < 4; i++) begin                // Same address read and write
      a = rand_addr();
      d = rand_word();
      set_write(0, a, d);
      set_read(0, a);
      tick();
      set_read(0, a);
      tick();
    end

    repeat (3) tick();
    $display("Checks finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- hw/memory_bank.sv
// Top of the memory bank: routing table, crossbar and one memory per slot
// Strobes are single-cycle pulses with no back-pressure, all accepted
// Per-port and per-memory groups are packed with index i in slice i
`timescale 1ns/100ps

module memory_bank #(
  parameter int data_width      = mem_bank_pkg::DATA_WIDTH_DEF,
  parameter int num_addresses   = mem_bank_pkg::NUM_ADDRESSES_DEF,
  parameter int block_depth     = mem_bank_pkg::BLOCK_DEPTH_DEF,
  parameter int num_memories    = mem_bank_pkg::NUM_MEMORIES_DEF,
  parameter int num_read_ports  = mem_bank_pkg::NUM_READ_PORTS_DEF,
  parameter int num_write_ports = mem_bank_pkg::NUM_WRITE_PORTS_DEF,
  localparam int addr_w = (num_addresses > 1) ? $clog2(num_addresses) : 1,
  localparam int mem_w  = (num_memories > 1) ? $clog2(num_memories) : 1,
  localparam int rp_w   = (num_read_ports > 1) ? $clog2(num_read_ports) : 1,
  localparam int wp_w   = (num_write_ports > 1) ? $clog2(num_write_ports) : 1
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  cmd_assign,
  input  logic                                  cmd_unassign,
  input  logic [rp_w-1:0]                       read_port,
  input  logic [wp_w-1:0]                       write_port,
  input  logic [mem_w-1:0]                      memory,
  input  logic [num_write_ports-1:0]            write_in,
  input  logic [num_write_ports*addr_w-1:0]     write_addr_in,
  input  logic [num_write_ports*data_width-1:0] write_data_in,
  input  logic [num_read_ports-1:0]             read_in,
  input  logic [num_read_ports*addr_w-1:0]      read_addr_in,
  output logic [num_read_ports-1:0]             read_valid_out,
  output logic [num_read_ports*data_width-1:0]  read_data_out
);

  logic [num_memories*rp_w-1:0]       mem_read_sel;
  logic [num_memories-1:0]            mem_read_en;
  logic [num_memories*wp_w-1:0]       mem_write_sel;
  logic [num_memories-1:0]            mem_write_en;
  logic [num_read_ports*mem_w-1:0]    port_mem_sel;
  logic [num_read_ports-1:0]          port_bound;
  logic [num_memories-1:0]            mem_write;
  logic [num_memories*addr_w-1:0]     mem_addr_write;
  logic [num_memories*data_width-1:0] mem_data_write;
  logic [num_memories-1:0]            mem_read;
  logic [num_memories*addr_w-1:0]     mem_addr_read;
  logic [num_memories*data_width-1:0] mem_data_read;
  logic [num_memories-1:0]            mem_valid;

  port_map_table #(
    .num_memories    (num_memories),
    .num_read_ports  (num_read_ports),
    .num_write_ports (num_write_ports)
  ) port_map_table_i (
    .clk          (clk),          .rst          (rst),
    .cmd_assign   (cmd_assign),   .cmd_unassign (cmd_unassign),
    .read_port    (read_port),    .write_port   (write_port),
    .memory       (memory),
    .mem_read_sel (mem_read_sel), .mem_read_en  (mem_read_en),
    .mem_write_sel(mem_write_sel),.mem_write_en (mem_write_en),
    .port_mem_sel (port_mem_sel), .port_bound   (port_bound)
  );

  port_crossbar #(
    .data_width      (data_width),
    .num_addresses   (num_addresses),
    .num_memories    (num_memories),
    .num_read_ports  (num_read_ports),
    .num_write_ports (num_write_ports)
  ) port_crossbar_i (
    .mem_read_sel   (mem_read_sel),   .mem_read_en    (mem_read_en),
    .mem_write_sel  (mem_write_sel),  .mem_write_en   (mem_write_en),
    .port_mem_sel   (port_mem_sel),   .port_bound     (port_bound),
    .write_in       (write_in),       .write_addr_in  (write_addr_in),
    .write_data_in  (write_data_in),  .read_in        (read_in),
    .read_addr_in   (read_addr_in),   .read_valid_out (read_valid_out),
    .read_data_out  (read_data_out),  .mem_data_read  (mem_data_read),
    .mem_valid      (mem_valid),      .mem_write      (mem_write),
    .mem_addr_write (mem_addr_write), .mem_data_write (mem_data_write),
    .mem_read       (mem_read),       .mem_addr_read  (mem_addr_read)
  );

  // One memory per table slot
  for (genvar m = 0; m < num_memories; m++) begin : g_mem
    banked_memory #(
      .data_width    (data_width),
      .num_addresses (num_addresses),
      .block_depth   (block_depth)
    ) banked_memory_i (
      .clk        (clk),
      .rst        (rst),
      .write      (mem_write[m]),
      .addr_write (mem_addr_write[m*addr_w +: addr_w]),
      .data_write (mem_data_write[m*data_width +: data_width]),
      .read       (mem_read[m]),
      .addr_read  (mem_addr_read[m*addr_w +: addr_w]),
      .data_read  (mem_data_read[m*data_width +: data_width]),
      .valid_out  (mem_valid[m])
    );
  end

endmodule

//--- hw/port_crossbar.sv
// Crossbar between the outside ports and the memories of the bank
// Purely combinational, all timing comes from the table and the memories
// Several memories may share one write port and are all written
`timescale 1ns/100ps

module port_crossbar #(
  parameter int data_width      = mem_bank_pkg::DATA_WIDTH_DEF,
  parameter int num_addresses   = mem_bank_pkg::NUM_ADDRESSES_DEF,
  parameter int num_memories    = mem_bank_pkg::NUM_MEMORIES_DEF,
  parameter int num_read_ports  = mem_bank_pkg::NUM_READ_PORTS_DEF,
  parameter int num_write_ports = mem_bank_pkg::NUM_WRITE_PORTS_DEF,
  localparam int addr_w = (num_addresses > 1) ? $clog2(num_addresses) : 1,
  localparam int mem_w  = (num_memories > 1) ? $clog2(num_memories) : 1,
  localparam int rp_w   = (num_read_ports > 1) ? $clog2(num_read_ports) : 1,
  localparam int wp_w   = (num_write_ports > 1) ? $clog2(num_write_ports) : 1
) (
  // Routing state from the table
  input  logic [num_memories*rp_w-1:0]          mem_read_sel,
  input  logic [num_memories-1:0]               mem_read_en,
  input  logic [num_memories*wp_w-1:0]          mem_write_sel,
  input  logic [num_memories-1:0]               mem_write_en,
  input  logic [num_read_ports*mem_w-1:0]       port_mem_sel,
  input  logic [num_read_ports-1:0]             port_bound,
  // Outside traffic
  input  logic [num_write_ports-1:0]            write_in,
  input  logic [num_write_ports*addr_w-1:0]     write_addr_in,
  input  logic [num_write_ports*data_width-1:0] write_data_in,
  input  logic [num_read_ports-1:0]             read_in,
  input  logic [num_read_ports*addr_w-1:0]      read_addr_in,
  output logic [num_read_ports-1:0]             read_valid_out,
  output logic [num_read_ports*data_width-1:0]  read_data_out,
  // Memory side
  input  logic [num_memories*data_width-1:0]    mem_data_read,
  input  logic [num_memories-1:0]               mem_valid,
  output logic [num_memories-1:0]               mem_write,
  output logic [num_memories*addr_w-1:0]        mem_addr_write,
  output logic [num_memories*data_width-1:0]    mem_data_write,
  output logic [num_memories-1:0]               mem_read,
  output logic [num_memories*addr_w-1:0]        mem_addr_read
);

  // --------------------------------------------------------------------------
  // Ports into memories
  // --------------------------------------------------------------------------
  for (genvar m = 0; m < num_memories; m++) begin : g_mem
    logic [rp_w-1:0] rsel;                                   // Bound read port
    logic [wp_w-1:0] wsel;                                   // Bound write port

    assign rsel = mem_read_sel[m*rp_w +: rp_w];
    assign wsel = mem_write_sel[m*wp_w +: wp_w];

    assign mem_write[m] = mem_write_en[m] & write_in[wsel];  // Gated by binding
    assign mem_addr_write[m*addr_w +: addr_w]         = write_addr_in[wsel*addr_w +: addr_w];
    assign mem_data_write[m*data_width +: data_width] = write_data_in[wsel*data_width +: data_width];
    assign mem_read[m]  = mem_read_en[m] & read_in[rsel];
    assign mem_addr_read[m*addr_w +: addr_w]          = read_addr_in[rsel*addr_w +: addr_w];
  end

  // --------------------------------------------------------------------------
  // Memories back to read ports
  // --------------------------------------------------------------------------
  for (genvar r = 0; r < num_read_ports; r++) begin : g_port
    logic [mem_w-1:0] msel;                                  // Memory this port sees

    assign msel = port_mem_sel[r*mem_w +: mem_w];

    assign read_valid_out[r] = port_bound[r] & mem_valid[msel];  // Unbound gives 0
    assign read_data_out[r*data_width +: data_width] =
      port_bound[r] ? mem_data_read[msel*data_width +: data_width] : '0;
  end

endmodule

//--- hw/port_map_table.sv
// Routing table of the memory bank
// A command in cycle t takes effect from cycle t+1, assign wins over unassign
// Ids beyond the configured counts are not checked and must not be issued
`timescale 1ns/100ps

module port_map_table #(
  parameter int num_memories    = mem_bank_pkg::NUM_MEMORIES_DEF,
  parameter int num_read_ports  = mem_bank_pkg::NUM_READ_PORTS_DEF,
  parameter int num_write_ports = mem_bank_pkg::NUM_WRITE_PORTS_DEF,
  localparam int mem_w = (num_memories > 1) ? $clog2(num_memories) : 1,
  localparam int rp_w  = (num_read_ports > 1) ? $clog2(num_read_ports) : 1,
  localparam int wp_w  = (num_write_ports > 1) ? $clog2(num_write_ports) : 1
) (
  input  logic                           clk,
  input  logic                           rst,           // Synchronous, active low
  input  logic                           cmd_assign,    // Bind memory to both ports
  input  logic                           cmd_unassign,  // Release memory and read port
  input  logic [rp_w-1:0]                read_port,
  input  logic [wp_w-1:0]                write_port,
  input  logic [mem_w-1:0]               memory,
  output logic [num_memories*rp_w-1:0]   mem_read_sel,  // Read port feeding each memory
  output logic [num_memories-1:0]        mem_read_en,   // Memory listens to its read port
  output logic [num_memories*wp_w-1:0]   mem_write_sel, // Write port feeding each memory
  output logic [num_memories-1:0]        mem_write_en,  // Memory listens to its write port
  output logic [num_read_ports*mem_w-1:0] port_mem_sel, // Memory seen by each read port
  output logic [num_read_ports-1:0]      port_bound     // Read port has a memory
);

  // --------------------------------------------------------------------------
  // Table update
  // --------------------------------------------------------------------------
  // Only the commanded entries move, everything else holds. A memory whose
  // read port was taken over by another memory keeps its read flag. Its reads
  // still happen but the port no longer returns them.
  always_ff @(posedge clk) begin
    if (!rst) begin
      mem_read_sel  <= '0;
      mem_read_en   <= '0;
      mem_write_sel <= '0;
      mem_write_en  <= '0;
      port_mem_sel  <= '0;
      port_bound    <= '0;
    end else if (cmd_assign) begin
      mem_read_sel[memory*rp_w +: rp_w]        <= read_port;  // Memory side, read
      mem_write_sel[memory*wp_w +: wp_w]       <= write_port; // Memory side, write
      mem_read_en[memory]                      <= 1'b1;
      mem_write_en[memory]                     <= 1'b1;
      port_mem_sel[read_port*mem_w +: mem_w]   <= memory;     // Port side, return path
      port_bound[read_port]                    <= 1'b1;
    end else if (cmd_unassign) begin
      mem_read_en[memory]                      <= 1'b0;       // Stop strobes into memory
      mem_write_en[memory]                     <= 1'b0;
      port_bound[read_port]                    <= 1'b0;       // Port returns zero from now
    end
  end

endmodule

//--- hw/banked_memory.sv
// One memory of the bank, built from equal blocks picked by the upper address
// bits. Block depth is a power of two of at least 2 that divides the depth.
// Read data and valid arrive one cycle after the read strobe
`timescale 1ns/100ps

module banked_memory #(
  parameter int data_width    = mem_bank_pkg::DATA_WIDTH_DEF,
  parameter int num_addresses = mem_bank_pkg::NUM_ADDRESSES_DEF,
  parameter int block_depth   = mem_bank_pkg::BLOCK_DEPTH_DEF,
  localparam int addr_w     = (num_addresses > 1) ? $clog2(num_addresses) : 1,
  localparam int num_blocks = num_addresses / block_depth,
  localparam int blk_addr_w = (block_depth > 1) ? $clog2(block_depth) : 1,
  localparam int blk_sel_w  = (num_blocks > 1) ? $clog2(num_blocks) : 1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  write,
  input  logic [addr_w-1:0]     addr_write,
  input  logic [data_width-1:0] data_write,
  input  logic                  read,
  input  logic [addr_w-1:0]     addr_read,
  output logic [data_width-1:0] data_read,
  output logic                  valid_out    // Read strobe delayed by one cycle
);

  logic [blk_sel_w-1:0]  wr_blk;             // Block hit by the write
  logic [blk_sel_w-1:0]  rd_blk;             // Block hit by the read
  logic [blk_sel_w-1:0]  rd_blk_q;           // Block of the last read
  logic [data_width-1:0] blk_data [num_blocks];

  // Upper bits pick the block, zero when there is only one
  assign wr_blk = blk_sel_w'(addr_write >> blk_addr_w);
  assign rd_blk = blk_sel_w'(addr_read >> blk_addr_w);

  // --------------------------------------------------------------------------
  // Blocks
  // --------------------------------------------------------------------------
  for (genvar b = 0; b < num_blocks; b++) begin : g_blk
    block_ram #(
      .data_width (data_width),
      .depth      (block_depth)
    ) block_ram_i (
      .clk        (clk),
      .write      (write && (wr_blk == blk_sel_w'(b))),   // One-hot block write
      .addr_write (addr_write[blk_addr_w-1:0]),
      .data_write (data_write),
      .read       (read && (rd_blk == blk_sel_w'(b))),    // Only the addressed block reads
      .addr_read  (addr_read[blk_addr_w-1:0]),
      .data_read  (blk_data[b])
    );
  end

  // Select follows reads only, so output holds while the address moves
  always_ff @(posedge clk) begin
    if (!rst) begin
      rd_blk_q  <= '0;
      valid_out <= 1'b0;
    end else begin
      valid_out <= read;
      if (read) begin
        rd_blk_q <= rd_blk;
      end
    end
  end

  assign data_read = blk_data[rd_blk_q];     // Output of the block read last

endmodule

//--- hw/block_ram.sv
// Behavioural simple-dual-port block, one write and one read per cycle
// Read data is registered and only changes on a read strobe
// Same-address read and write return the old word
`timescale 1ns/100ps

module block_ram #(
  parameter int data_width = 32,
  parameter int depth      = 1024,
  localparam int addr_w = (depth > 1) ? $clog2(depth) : 1
) (
  input  logic                  clk,
  input  logic                  write,       // Write strobe for this block
  input  logic [addr_w-1:0]     addr_write,
  input  logic [data_width-1:0] data_write,
  input  logic                  read,        // Read strobe for this block
  input  logic [addr_w-1:0]     addr_read,
  output logic [data_width-1:0] data_read    // Holds between reads
);

  logic [data_width-1:0] mem [depth];        // Storage, contents not reset

  always_ff @(posedge clk) begin
    if (write) begin
      mem[addr_write] <= data_write;
    end
  end

  // Nonblocking read samples the array before this edge's write lands
  always_ff @(posedge clk) begin
    if (read) begin
      data_read <= mem[addr_read];           // Read-first on collision
    end
  end

endmodule

//--- hw/mem_bank_pkg.sv
// Default geometry shared by the bank, the crossbar and the memories
// Word counts and block depths are powers of two, and a block depth
// divides the memory depth
package mem_bank_pkg;

  // --------------------------------------------------------------------------
  // Word and memory geometry
  // --------------------------------------------------------------------------
  localparam int DATA_WIDTH_DEF    = 32;    // Bits per word
  localparam int NUM_ADDRESSES_DEF = 4096;  // Words per memory
  localparam int BLOCK_DEPTH_DEF   = 1024;  // Words per block, four blocks per memory

  // --------------------------------------------------------------------------
  // Bank organisation
  // --------------------------------------------------------------------------
  localparam int NUM_MEMORIES_DEF    = 4;   // Memories in the bank
  localparam int NUM_READ_PORTS_DEF  = 2;   // Read ports seen from outside
  localparam int NUM_WRITE_PORTS_DEF = 2;   // Write ports seen from outside

  // Port ids, memory ids and addresses are sized as ceil(log2(count)) in each
  // module, with a floor of one bit so that single-entry counts stay legal

endpackage
